// ==== include/mem_settings.svh ====
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// bus widths
`define MEM_ADDR_W 32
`define MEM_DATA_W 32

// word memory model, indexed by addr[..:2]
`define MEM_DEPTH 256

// cycles from read acceptance to response
`define MEM_READ_LAT 2

// ready drops one cycle in every period
`define MEM_STALL_PERIOD 4

`endif

// ==== verilog/mem_pkg.sv ====
`include "mem_settings.svh"

package mem_pkg;

    // instruction fetch request
    typedef struct packed {
        logic                   valid;
        logic [`MEM_ADDR_W-1:0] addr;
    } ireq_t;

    // data load/store request
    typedef struct packed {
        logic                   valid;
        logic                   wen;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] wdata;
    } dreq_t;

    // command controller states
    typedef enum logic [1:0] {
        WAIT_CMD,
        WAIT_READY,
        WAIT_READ_VALID
    } cmd_state_t;

endpackage

// ==== verilog/req_hold.sv ====
`include "mem_settings.svh"

module req_hold #(
    parameter type payload_t = mem_pkg::ireq_t
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     capture,
    input  logic     clear_valid,
    input  payload_t d,
    output payload_t q
);

    payload_t data_q;
    logic     valid_q;

    // pending flag, capture wins over clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (capture) begin
            valid_q <= d.valid;
        end else if (clear_valid) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= d;
        end
    end

    // payload with the tracked valid folded back in
    always_comb begin
        q       = data_q;
        q.valid = valid_q;
    end

endmodule

// ==== verilog/mem_cmd_ctrl.sv ====
`include "mem_settings.svh"

module mem_cmd_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ireq_valid,
    input  logic [`MEM_ADDR_W-1:0] ireq_addr,
    input  logic                   dreq_valid,
    input  logic                   dreq_wen,
    input  logic [`MEM_ADDR_W-1:0] dreq_addr,
    input  logic [`MEM_DATA_W-1:0] dreq_wdata,
    input  mem_pkg::ireq_t         held_ireq,
    input  mem_pkg::dreq_t         held_dreq,
    input  logic                   mem_req_ready,
    input  logic                   mem_resp_valid,
    output logic                   req_ready,
    output logic                   capture,
    output logic                   clear_ireq,
    output logic                   mem_req_valid,
    output logic                   mem_req_wen,
    output logic [`MEM_ADDR_W-1:0] mem_req_addr,
    output logic [`MEM_DATA_W-1:0] mem_req_wdata,
    output logic                   read_is_fetch,
    output logic                   read_phase
);

    mem_pkg::cmd_state_t state;
    mem_pkg::cmd_state_t state_nxt;
    mem_pkg::cmd_state_t issue_state;

    logic                   live_any;
    logic                   held_both;
    logic                   read_done;
    logic                   cmd_gate;
    logic                   src_ivalid;
    logic [`MEM_ADDR_W-1:0] src_iaddr;
    logic                   src_dvalid;
    logic                   src_dwen;
    logic [`MEM_ADDR_W-1:0] src_daddr;
    logic [`MEM_DATA_W-1:0] src_dwdata;

    assign live_any   = ireq_valid | dreq_valid;
    assign held_both  = held_ireq.valid & held_dreq.valid;
    assign read_phase = (state == mem_pkg::WAIT_READ_VALID);
    assign read_done  = read_phase & mem_resp_valid;

    // a held fetch means the outstanding read is the fetch
    assign read_is_fetch = held_ireq.valid;

    // new requests only when idle or when the last read returns with nothing queued
    assign req_ready  = (state == mem_pkg::WAIT_CMD) | (read_done & ~held_both);
    assign capture    = req_ready & live_any;
    assign clear_ireq = read_done & held_both;

    // pick where the next memory command comes from
    always_comb begin
        src_ivalid = ireq_valid;
        src_iaddr  = ireq_addr;
        src_dvalid = dreq_valid;
        src_dwen   = dreq_wen;
        src_daddr  = dreq_addr;
        src_dwdata = dreq_wdata;
        if (state == mem_pkg::WAIT_READY) begin
            // retry whatever is held, fetch first
            src_ivalid = held_ireq.valid;
            src_iaddr  = held_ireq.addr;
            src_dvalid = held_dreq.valid;
            src_dwen   = held_dreq.wen;
            src_daddr  = held_dreq.addr;
            src_dwdata = held_dreq.wdata;
        end else if (read_phase && held_both) begin
            // fetch of a pair done, second half goes out now
            src_ivalid = 1'b0;
            src_dvalid = held_dreq.valid;
            src_dwen   = held_dreq.wen;
            src_daddr  = held_dreq.addr;
            src_dwdata = held_dreq.wdata;
        end
    end

    // nothing may issue while a read is still in flight
    assign cmd_gate      = ~read_phase | mem_resp_valid;
    assign mem_req_valid = cmd_gate & (src_ivalid | src_dvalid);
    assign mem_req_wen   = ~src_ivalid & src_dvalid & src_dwen;
    assign mem_req_addr  = src_ivalid ? src_iaddr : src_daddr;
    assign mem_req_wdata = src_dwdata;

    // where an issued command leads
    always_comb begin
        if (!mem_req_ready) begin
            issue_state = mem_pkg::WAIT_READY;
        end else if (mem_req_wen) begin
            issue_state = mem_pkg::WAIT_CMD;
        end else begin
            issue_state = mem_pkg::WAIT_READ_VALID;
        end
    end

    always_comb begin
        if (mem_req_valid) begin
            state_nxt = issue_state;
        end else if (read_done) begin
            state_nxt = mem_pkg::WAIT_CMD;
        end else begin
            state_nxt = state;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mem_pkg::WAIT_CMD;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

// ==== verilog/resp_route.sv ====
`include "mem_settings.svh"

module resp_route (
    input  logic                   mem_resp_valid,
    input  logic [`MEM_DATA_W-1:0] mem_resp_rdata,
    input  logic                   read_is_fetch,
    input  logic                   read_phase,
    input  logic [`MEM_ADDR_W-1:0] held_ireq_addr,
    input  logic [`MEM_ADDR_W-1:0] held_dreq_addr,
    output logic                   iresp_valid,
    output logic [`MEM_ADDR_W-1:0] iresp_addr,
    output logic [`MEM_DATA_W-1:0] iresp_inst,
    output logic                   dresp_valid,
    output logic [`MEM_ADDR_W-1:0] dresp_addr,
    output logic [`MEM_DATA_W-1:0] dresp_rdata
);

    logic returning;

    // read data only counts while the controller waits for it
    assign returning = mem_resp_valid & read_phase;

    // fetch side
    assign iresp_valid = returning & read_is_fetch;
    assign iresp_addr  = held_ireq_addr;
    assign iresp_inst  = mem_resp_rdata;

    // data side
    assign dresp_valid = returning & ~read_is_fetch;
    assign dresp_addr  = held_dreq_addr;
    assign dresp_rdata = mem_resp_rdata;

endmodule

// ==== verilog/mem_store.sv ====
`include "mem_settings.svh"

module mem_store (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  logic                   req_wen,
    input  logic [`MEM_ADDR_W-1:0] req_addr,
    input  logic [`MEM_DATA_W-1:0] req_wdata,
    output logic                   req_ready,
    output logic                   resp_valid,
    output logic [`MEM_DATA_W-1:0] resp_rdata
);

    localparam int IDX_W   = $clog2(`MEM_DEPTH);
    localparam int LAT     = `MEM_READ_LAT;
    localparam int STALL_W = $clog2(`MEM_STALL_PERIOD + 1);
    localparam logic [LAT-1:0] LAST_STAGE = LAT'(1) << (LAT - 1);

    logic [`MEM_DATA_W-1:0] mem [`MEM_DEPTH];
    logic [`MEM_DATA_W-1:0] rdata_pipe [LAT];
    logic [LAT-1:0]         valid_pipe;
    logic [STALL_W-1:0]     stall_cnt;
    logic [IDX_W-1:0]       idx;
    logic                   stall;
    logic                   busy;
    logic                   rd_accept;
    logic                   wr_accept;

    // word address, wraps at the depth
    assign idx = req_addr[IDX_W+1:2];

    // free-running stall pattern
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_cnt <= '0;
        end else if (stall) begin
            stall_cnt <= '0;
        end else begin
            stall_cnt <= stall_cnt + 1'b1;
        end
    end

    assign stall = (stall_cnt == STALL_W'(`MEM_STALL_PERIOD - 1));

    // busy until the read reaches its last stage
    assign busy      = |(valid_pipe & ~LAST_STAGE);
    assign req_ready = ~stall & ~busy;
    assign rd_accept = req_valid & req_ready & ~req_wen;
    assign wr_accept = req_valid & req_ready & req_wen;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= (valid_pipe << 1) | LAT'(rd_accept);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            mem[idx] <= req_wdata;
        end
    end

    // word sampled at acceptance, then delayed
    always_ff @(posedge clk) begin
        rdata_pipe[0] <= mem[idx];
        for (int i = 1; i < LAT; i++) begin
            rdata_pipe[i] <= rdata_pipe[i-1];
        end
    end

    assign resp_valid = valid_pipe[LAT-1];
    assign resp_rdata = rdata_pipe[LAT-1];

endmodule

// ==== verilog/mem_subsys_top.sv ====
`include "mem_settings.svh"

module mem_subsys_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ireq_valid,
    input  logic [`MEM_ADDR_W-1:0] ireq_addr,
    output logic                   ireq_ready,
    output logic                   iresp_valid,
    output logic [`MEM_ADDR_W-1:0] iresp_addr,
    output logic [`MEM_DATA_W-1:0] iresp_inst,
    input  logic                   dreq_valid,
    input  logic                   dreq_wen,
    input  logic [`MEM_ADDR_W-1:0] dreq_addr,
    input  logic [`MEM_DATA_W-1:0] dreq_wdata,
    output logic                   dreq_ready,
    output logic                   dresp_valid,
    output logic [`MEM_ADDR_W-1:0] dresp_addr,
    output logic [`MEM_DATA_W-1:0] dresp_rdata
);

    mem_pkg::ireq_t         live_ireq;
    mem_pkg::dreq_t         live_dreq;
    mem_pkg::ireq_t         held_ireq;
    mem_pkg::dreq_t         held_dreq;
    logic                   req_ready;
    logic                   capture;
    logic                   clear_ireq;
    logic                   mem_req_valid;
    logic                   mem_req_wen;
    logic [`MEM_ADDR_W-1:0] mem_req_addr;
    logic [`MEM_DATA_W-1:0] mem_req_wdata;
    logic                   mem_req_ready;
    logic                   mem_resp_valid;
    logic [`MEM_DATA_W-1:0] mem_resp_rdata;
    logic                   read_is_fetch;
    logic                   read_phase;

    // live port payloads for the holding registers
    assign live_ireq = '{valid: ireq_valid, addr: ireq_addr};
    assign live_dreq = '{valid: dreq_valid, wen: dreq_wen, addr: dreq_addr, wdata: dreq_wdata};

    // one ready shared by both ports
    assign ireq_ready = req_ready;
    assign dreq_ready = req_ready;

    mem_cmd_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .ireq_valid     (ireq_valid),
        .ireq_addr      (ireq_addr),
        .dreq_valid     (dreq_valid),
        .dreq_wen       (dreq_wen),
        .dreq_addr      (dreq_addr),
        .dreq_wdata     (dreq_wdata),
        .held_ireq      (held_ireq),
        .held_dreq      (held_dreq),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .req_ready      (req_ready),
        .capture        (capture),
        .clear_ireq     (clear_ireq),
        .mem_req_valid  (mem_req_valid),
        .mem_req_wen    (mem_req_wen),
        .mem_req_addr   (mem_req_addr),
        .mem_req_wdata  (mem_req_wdata),
        .read_is_fetch  (read_is_fetch),
        .read_phase     (read_phase)
    );

    req_hold #(.payload_t(mem_pkg::ireq_t)) u_ihold (
        .clk         (clk),
        .rst_n       (rst_n),
        .capture     (capture),
        .clear_valid (clear_ireq),
        .d           (live_ireq),
        .q           (held_ireq)
    );

    // data entry is only ever replaced by the next capture
    req_hold #(.payload_t(mem_pkg::dreq_t)) u_dhold (
        .clk         (clk),
        .rst_n       (rst_n),
        .capture     (capture),
        .clear_valid (1'b0),
        .d           (live_dreq),
        .q           (held_dreq)
    );

    resp_route u_route (
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_rdata (mem_resp_rdata),
        .read_is_fetch  (read_is_fetch),
        .read_phase     (read_phase),
        .held_ireq_addr (held_ireq.addr),
        .held_dreq_addr (held_dreq.addr),
        .iresp_valid    (iresp_valid),
        .iresp_addr     (iresp_addr),
        .iresp_inst     (iresp_inst),
        .dresp_valid    (dresp_valid),
        .dresp_addr     (dresp_addr),
        .dresp_rdata    (dresp_rdata)
    );

    mem_store u_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (mem_req_valid),
        .req_wen    (mem_req_wen),
        .req_addr   (mem_req_addr),
        .req_wdata  (mem_req_wdata),
        .req_ready  (mem_req_ready),
        .resp_valid (mem_resp_valid),
        .resp_rdata (mem_resp_rdata)
    );

endmodule

// ==== dv/mem_subsys_sva.sv ====
`include "mem_settings.svh"

module mem_subsys_sva (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   req_ready,
    input logic                   mem_req_valid,
    input logic                   mem_req_ready,
    input logic                   mem_req_wen,
    input logic [`MEM_ADDR_W-1:0] mem_req_addr,
    input logic                   mem_resp_valid,
    input logic                   read_is_fetch,
    input logic                   read_phase,
    input mem_pkg::ireq_t         held_ireq,
    input mem_pkg::dreq_t         held_dreq
);

    timeunit 1ns;
    timeprecision 1ps;

    logic fetch_resp;
    logic data_resp;

    // the two response pulses as the router forms them
    assign fetch_resp = read_phase & mem_resp_valid & read_is_fetch;
    assign data_resp  = read_phase & mem_resp_valid & ~read_is_fetch;

    // command stays put until the memory takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=>
            mem_req_valid && $stable(mem_req_addr) && $stable(mem_req_wen))
        else $error("memory command dropped or changed before acceptance");

    // each read return turns into one response pulse, never none and never both
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_resp_valid |-> (fetch_resp ^ data_resp))
        else $error("read return not routed to exactly one response port");

    assert property (@(posedge clk) disable iff (!rst_n)
        held_ireq.valid && held_dreq.valid |-> !req_ready)
        else $error("ready high with both requests held");

    // first edge out of reset
    assert property (@(posedge clk) $rose(rst_n) |->
        req_ready && !mem_req_valid && !read_phase && !held_ireq.valid
            && !held_dreq.valid && !fetch_resp && !data_resp)
        else $error("controller not idle after reset");

endmodule

bind mem_cmd_ctrl mem_subsys_sva u_sva (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_ready      (req_ready),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_wen    (mem_req_wen),
    .mem_req_addr   (mem_req_addr),
    .mem_resp_valid (mem_resp_valid),
    .read_is_fetch  (read_is_fetch),
    .read_phase     (read_phase),
    .held_ireq      (held_ireq),
    .held_dreq      (held_dreq)
);

// ==== dv/mem_subsys_tb.sv ====
`include "mem_settings.svh"

module mem_subsys_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int IDX_W           = $clog2(`MEM_DEPTH);
    localparam int FILL_WORDS      = 32;
    localparam int RAND_REQS       = 200;
    localparam int TOTAL_REQS      = 2 * FILL_WORDS + 16 + 16 + 12 + RAND_REQS;
    localparam int WATCHDOG_CYCLES = TOTAL_REQS * (`MEM_READ_LAT + `MEM_STALL_PERIOD + 4) * 2;

    logic                   clk;
    logic                   rst_n;
    logic                   ireq_valid;
    logic [`MEM_ADDR_W-1:0] ireq_addr;
    logic                   ireq_ready;
    logic                   iresp_valid;
    logic [`MEM_ADDR_W-1:0] iresp_addr;
    logic [`MEM_DATA_W-1:0] iresp_inst;
    logic                   dreq_valid;
    logic                   dreq_wen;
    logic [`MEM_ADDR_W-1:0] dreq_addr;
    logic [`MEM_DATA_W-1:0] dreq_wdata;
    logic                   dreq_ready;
    logic                   dresp_valid;
    logic [`MEM_ADDR_W-1:0] dresp_addr;
    logic [`MEM_DATA_W-1:0] dresp_rdata;

    // shadow copy of the word memory
    logic [`MEM_DATA_W-1:0] shadow [`MEM_DEPTH];

    // expected responses, oldest first
    logic [`MEM_ADDR_W-1:0] fetch_addr_q [$];
    logic [`MEM_DATA_W-1:0] fetch_data_q [$];
    logic [`MEM_ADDR_W-1:0] data_addr_q [$];
    logic [`MEM_DATA_W-1:0] data_data_q [$];

    int seed;
    int checks;
    int errors;
    int resp_seq;
    int last_iresp_seq;
    int last_dresp_seq;

    mem_subsys_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .ireq_valid  (ireq_valid),
        .ireq_addr   (ireq_addr),
        .ireq_ready  (ireq_ready),
        .iresp_valid (iresp_valid),
        .iresp_addr  (iresp_addr),
        .iresp_inst  (iresp_inst),
        .dreq_valid  (dreq_valid),
        .dreq_wen    (dreq_wen),
        .dreq_addr   (dreq_addr),
        .dreq_wdata  (dreq_wdata),
        .dreq_ready  (dreq_ready),
        .dresp_valid (dresp_valid),
        .dresp_addr  (dresp_addr),
        .dresp_rdata (dresp_rdata)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // word address modulo the depth
    function automatic logic [IDX_W-1:0] word_index(input logic [`MEM_ADDR_W-1:0] addr);
        return IDX_W'((addr >> 2) % `MEM_DEPTH);
    endfunction

    function automatic logic [`MEM_DATA_W-1:0] ref_word(input logic [`MEM_ADDR_W-1:0] addr);
        return shadow[word_index(addr)];
    endfunction

    task automatic check_inst(input logic [`MEM_ADDR_W-1:0] got_addr,
                              input logic [`MEM_DATA_W-1:0] got_inst,
                              input logic [`MEM_ADDR_W-1:0] exp_addr,
                              input logic [`MEM_DATA_W-1:0] exp_inst);
        checks++;
        if (got_addr !== exp_addr) begin
            $display("FAILED iresp_addr: got %h expected %h", got_addr, exp_addr);
            errors++;
        end
        if (got_inst !== exp_inst) begin
            $display("FAILED iresp_inst: got %h expected %h", got_inst, exp_inst);
            errors++;
        end
    endtask

    task automatic check_rdata(input logic [`MEM_ADDR_W-1:0] got_addr,
                               input logic [`MEM_DATA_W-1:0] got_rdata,
                               input logic [`MEM_ADDR_W-1:0] exp_addr,
                               input logic [`MEM_DATA_W-1:0] exp_rdata);
        checks++;
        if (got_addr !== exp_addr) begin
            $display("FAILED dresp_addr: got %h expected %h", got_addr, exp_addr);
            errors++;
        end
        if (got_rdata !== exp_rdata) begin
            $display("FAILED dresp_rdata: got %h expected %h", got_rdata, exp_rdata);
            errors++;
        end
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic issue(input logic do_fetch, input logic [`MEM_ADDR_W-1:0] faddr,
                         input logic do_data, input logic wen,
                         input logic [`MEM_ADDR_W-1:0] daddr,
                         input logic [`MEM_DATA_W-1:0] wdata);
        logic taken;
        taken      = 1'b0;
        ireq_valid = do_fetch;
        ireq_addr  = faddr;
        dreq_valid = do_data;
        dreq_wen   = wen;
        dreq_addr  = daddr;
        dreq_wdata = wdata;
        while (!taken) begin
            #1;
            if (do_fetch ? ireq_ready : dreq_ready) begin
                taken = 1'b1;
                // fetch expectation first, a paired write lands after it
                if (do_fetch) begin
                    fetch_addr_q.push_back(faddr);
                    fetch_data_q.push_back(ref_word(faddr));
                end
                if (do_data && wen) begin
                    shadow[word_index(daddr)] = wdata;
                end else if (do_data) begin
                    data_addr_q.push_back(daddr);
                    data_data_q.push_back(ref_word(daddr));
                end
            end
            @(negedge clk);
        end
        ireq_valid = 1'b0;
        dreq_valid = 1'b0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    task automatic wait_drain();
        while (fetch_addr_q.size() != 0 || data_addr_q.size() != 0) begin
            @(negedge clk);
        end
        idle(4);
    endtask

    task automatic finish_test(input int num, input string name, input int errs_at_start);
        if (errors == errs_at_start) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - errs_at_start);
        end
    endtask

    // responses are stable between rising edges
    always @(negedge clk) begin
        if (rst_n) begin
            if (iresp_valid) begin
                resp_seq++;
                last_iresp_seq = resp_seq;
                if (fetch_addr_q.size() == 0) begin
                    $display("fetch response for address %h arrived with no fetch pending",
                             iresp_addr);
                    errors++;
                end else begin
                    check_inst(iresp_addr, iresp_inst, fetch_addr_q.pop_front(),
                               fetch_data_q.pop_front());
                end
            end
            if (dresp_valid) begin
                resp_seq++;
                last_dresp_seq = resp_seq;
                if (data_addr_q.size() == 0) begin
                    $display("data response for address %h arrived with no read pending",
                             dresp_addr);
                    errors++;
                end else begin
                    check_rdata(dresp_addr, dresp_rdata, data_addr_q.pop_front(),
                                data_data_q.pop_front());
                end
            end
        end
    end

    initial begin
        logic [31:0]            rnd;
        logic [31:0]            rnd2;
        logic [`MEM_ADDR_W-1:0] faddr;
        logic [`MEM_ADDR_W-1:0] daddr;
        logic [`MEM_DATA_W-1:0] word;
        int                     errs_at;
        int                     sent;
        int                     kind;

        seed           = 32'hf37a;
        checks         = 0;
        errors         = 0;
        resp_seq       = 0;
        last_iresp_seq = 0;
        last_dresp_seq = 0;
        rst_n          = 1'b0;
        ireq_valid     = 1'b0;
        ireq_addr      = '0;
        dreq_valid     = 1'b0;
        dreq_wen       = 1'b0;
        dreq_addr      = '0;
        dreq_wdata     = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        idle(2);

        errs_at = errors;
        for (int i = 0; i < FILL_WORDS; i++) begin
            word = $random(seed);
            issue(1'b0, '0, 1'b1, 1'b1, 32'(i * 4), word);
        end
        for (int i = 0; i < FILL_WORDS; i++) begin
            issue(1'b0, '0, 1'b1, 1'b0, 32'(i * 4), '0);
        end
        wait_drain();
        finish_test(1, "data write then read back", errs_at);

        errs_at = errors;
        for (int i = 0; i < 16; i++) begin
            issue(1'b1, 32'(i * 8), 1'b0, 1'b0, '0, '0);
        end
        wait_drain();
        finish_test(2, "fetch of written words", errs_at);

        errs_at = errors;
        for (int i = 0; i < 8; i++) begin
            issue(1'b1, 32'(i * 4), 1'b1, 1'b0, 32'((31 - i) * 4), '0);
            wait_drain();
            if (last_iresp_seq > last_dresp_seq) begin
                $display("pair %0d: data response came before the fetch response", i);
                errors++;
            end
        end
        finish_test(3, "fetch and data read together", errs_at);

        // fetch sees the old word, the read after sees the new one
        errs_at = errors;
        for (int i = 8; i < 12; i++) begin
            word = $random(seed);
            issue(1'b1, 32'(i * 4), 1'b1, 1'b1, 32'(i * 4), word);
        end
        for (int i = 8; i < 12; i++) begin
            issue(1'b0, '0, 1'b1, 1'b0, 32'(i * 4), '0);
        end
        wait_drain();
        finish_test(4, "fetch and data write to the same word", errs_at);

        // upper address bits alias onto the filled words
        errs_at = errors;
        sent    = 0;
        while (sent < RAND_REQS) begin
            rnd   = $random(seed);
            rnd2  = $random(seed);
            word  = $random(seed);
            faddr = (rnd2 & 32'hffff_fc00) | {25'd0, rnd[4:0], 2'b00};
            daddr = (rnd2 & 32'hffff_fc00) | {25'd0, rnd[14:10], 2'b00};
            kind  = int'({16'd0, rnd[31:16]} % 32'd5);
            case (kind)
                0: issue(1'b1, faddr, 1'b0, 1'b0, daddr, word);
                1: issue(1'b0, faddr, 1'b1, 1'b0, daddr, word);
                2: issue(1'b0, faddr, 1'b1, 1'b1, daddr, word);
                3: issue(1'b1, faddr, 1'b1, 1'b0, daddr, word);
                default: issue(1'b1, faddr, 1'b1, 1'b1, daddr, word);
            endcase
            sent = sent + ((kind >= 3) ? 2 : 1);
            idle(int'(rnd[9:8]));
        end
        wait_drain();
        finish_test(5, "random mix across stalls", errs_at);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== mem_subsys_top.f ====
+incdir+include
verilog/mem_pkg.sv
verilog/req_hold.sv
verilog/mem_cmd_ctrl.sv
verilog/resp_route.sv
verilog/mem_store.sv
verilog/mem_subsys_top.sv
dv/mem_subsys_sva.sv
dv/mem_subsys_tb.sv

// ==== Makefile ====
# Verilator build and run for the memory command subsystem

VERILATOR ?= verilator
TOP       ?= mem_subsys_tb
FILELIST  ?= mem_subsys_top.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Regression passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
